//--- include/axil_params.svh
`ifndef AXIL_PARAMS_SVH
`define AXIL_PARAMS_SVH

// Number of 32-bit words behind the slave. Word indices at or above this
// value are answered with an error response.
`define AXIL_MEM_DEPTH 128

// Byte lanes in one data word, one strobe bit per lane.
`define AXIL_LANES 4

// Response codes driven on bresp and rresp.
`define AXIL_RESP_OKAY 2'b00
`define AXIL_RESP_ERR 2'b11

`endif

//--- hw/axil_pkg.sv
package axil_pkg;

  // AXI4-Lite address. The slave treats it as a word index.
  typedef logic [31:0] addr_t;

  // Data word on the W and R channels.
  typedef logic [31:0] data_t;

  // Byte strobe, one bit per lane of data_t.
  typedef logic [3:0] strb_t;

  // Response code on the B and R channels.
  typedef logic [1:0] resp_t;

endpackage

//--- hw/regfile_pkg.sv
`include "axil_params.svh"

package regfile_pkg;

  // Index into the word memory.
  typedef logic [$clog2(`AXIL_MEM_DEPTH)-1:0] word_idx_t;

  // Controller states. Only one transaction is in flight at a time.
  typedef enum logic [2:0] {
    idle,
    wait_wdata,
    write_mem,
    write_resp,
    read_mem,
    read_resp,
    read_err
  } ctrl_state_t;

endpackage

//--- hw/mem_port_if.sv
`timescale 1ns/1ns

interface mem_port_if;

  logic                   wr_en;
  regfile_pkg::word_idx_t wr_idx;
  axil_pkg::data_t        wr_data;
  axil_pkg::strb_t        wr_strb;
  logic                   rd_en;
  regfile_pkg::word_idx_t rd_idx;
  axil_pkg::data_t        rd_data;

  modport ctrl (
    output wr_en, wr_idx, wr_data, wr_strb, rd_en, rd_idx,
    input  rd_data
  );

  modport mem (
    input  wr_en, wr_idx, wr_data, wr_strb, rd_en, rd_idx,
    output rd_data
  );

endinterface

//--- hw/axil_ctrl.sv
`timescale 1ns/1ns

`include "axil_params.svh"

module axil_ctrl (
  input  logic            s_axi_aclk,
  input  logic            s_axi_aresetn,

  input  logic            awvalid,
  output logic            awready,
  input  axil_pkg::addr_t awaddr,

  input  logic            wvalid,
  output logic            wready,
  input  axil_pkg::data_t wdata,
  input  axil_pkg::strb_t wstrb,

  output logic            bvalid,
  input  logic            bready,
  output axil_pkg::resp_t bresp,

  input  logic            arvalid,
  output logic            arready,
  input  axil_pkg::addr_t araddr,

  output logic            rvalid,
  input  logic            rready,
  output axil_pkg::data_t rdata,
  output axil_pkg::resp_t rresp,

  mem_port_if.ctrl        mem
);

  regfile_pkg::ctrl_state_t state;

  regfile_pkg::word_idx_t wr_idx_q;
  logic                   wr_ok_q;
  axil_pkg::data_t        wdata_q;
  axil_pkg::strb_t        wstrb_q;
  regfile_pkg::word_idx_t rd_idx_q;
  logic                   rd_ok_q;

  logic aw_take;
  logic ar_take;
  logic w_take;

  // An AR whose ready pulse is still out blocks a new AW, so the read
  // handshake always completes before the write side is looked at.
  assign aw_take = (state == regfile_pkg::idle) && !arready && awvalid;
  assign ar_take = (state == regfile_pkg::idle) && !arready && !awvalid && arvalid;
  assign w_take  = (state == regfile_pkg::wait_wdata) && !wready && wvalid;

  // Address, data and strobe are captured when ready is raised. The master
  // holds them stable until the handshake, so the captured copy is final.
  always_ff @(posedge s_axi_aclk) begin
    if (aw_take) begin
      wr_idx_q <= regfile_pkg::word_idx_t'(awaddr);
      wr_ok_q  <= (awaddr < `AXIL_MEM_DEPTH);
    end
    if (ar_take) begin
      rd_idx_q <= regfile_pkg::word_idx_t'(araddr);
      rd_ok_q  <= (araddr < `AXIL_MEM_DEPTH);
    end
    if (w_take) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      state   <= regfile_pkg::idle;
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= `AXIL_RESP_OKAY;
      rvalid  <= 1'b0;
      rresp   <= `AXIL_RESP_OKAY;
    end else begin
      case (state)
        regfile_pkg::idle: begin
          if (arready) begin
            // The AR handshake completes on this edge.
            arready <= 1'b0;
            if (rd_ok_q) begin
              state <= regfile_pkg::read_mem;
            end else begin
              rvalid <= 1'b1;
              rresp  <= `AXIL_RESP_ERR;
              state  <= regfile_pkg::read_err;
            end
          end else if (aw_take) begin
            awready <= 1'b1;
            state   <= regfile_pkg::wait_wdata;
          end else if (ar_take) begin
            arready <= 1'b1;
          end
        end

        regfile_pkg::wait_wdata: begin
          awready <= 1'b0;
          if (wready) begin
            wready <= 1'b0;
            if (wr_ok_q) begin
              state <= regfile_pkg::write_mem;
            end else begin
              bvalid <= 1'b1;
              bresp  <= `AXIL_RESP_ERR;
              state  <= regfile_pkg::write_resp;
            end
          end else if (w_take) begin
            wready <= 1'b1;
          end
        end

        // The memory takes the write on this edge.
        regfile_pkg::write_mem: begin
          bvalid <= 1'b1;
          bresp  <= `AXIL_RESP_OKAY;
          state  <= regfile_pkg::write_resp;
        end

        regfile_pkg::write_resp: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= regfile_pkg::idle;
          end
        end

        // The memory registers the word on this edge.
        regfile_pkg::read_mem: begin
          rvalid <= 1'b1;
          rresp  <= `AXIL_RESP_OKAY;
          state  <= regfile_pkg::read_resp;
        end

        regfile_pkg::read_resp, regfile_pkg::read_err: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= regfile_pkg::idle;
          end
        end

        default: begin
          state <= regfile_pkg::idle;
        end
      endcase
    end
  end

  // rd_data holds until the next rd_en, so rdata stays stable for as long
  // as rvalid waits for rready.
  assign rdata = (state == regfile_pkg::read_resp) ? mem.rd_data : '0;

  assign mem.wr_en   = (state == regfile_pkg::write_mem);
  assign mem.wr_idx  = wr_idx_q;
  assign mem.wr_data = wdata_q;
  assign mem.wr_strb = wstrb_q;
  assign mem.rd_en   = (state == regfile_pkg::read_mem);
  assign mem.rd_idx  = rd_idx_q;

endmodule

//--- hw/axil_word_mem.sv
`timescale 1ns/1ns

`include "axil_params.svh"

module axil_word_mem (
  input  logic    s_axi_aclk,
  input  logic    s_axi_aresetn,
  mem_port_if.mem port
);

  axil_pkg::data_t words [`AXIL_MEM_DEPTH];

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      for (int i = 0; i < `AXIL_MEM_DEPTH; i++) begin
        words[i] <= '0;
      end
      port.rd_data <= '0;
    end else begin
      // Each lane with its strobe bit set takes the new byte; the others
      // keep their stored value.
      if (port.wr_en) begin
        for (int b = 0; b < `AXIL_LANES; b++) begin
          if (port.wr_strb[b]) begin
            words[port.wr_idx][8*b +: 8] <= port.wr_data[8*b +: 8];
          end
        end
      end
      if (port.rd_en) begin
        port.rd_data <= words[port.rd_idx];
      end
    end
  end

endmodule

//--- hw/axil_slave_top.sv
`timescale 1ns/1ns

module axil_slave_top (
  input  logic            s_axi_aclk,
  input  logic            s_axi_aresetn,

  input  logic            s_axi_awvalid,
  output logic            s_axi_awready,
  input  axil_pkg::addr_t s_axi_awaddr,

  input  logic            s_axi_wvalid,
  output logic            s_axi_wready,
  input  axil_pkg::data_t s_axi_wdata,
  input  axil_pkg::strb_t s_axi_wstrb,

  output logic            s_axi_bvalid,
  input  logic            s_axi_bready,
  output axil_pkg::resp_t s_axi_bresp,

  input  logic            s_axi_arvalid,
  output logic            s_axi_arready,
  input  axil_pkg::addr_t s_axi_araddr,

  output logic            s_axi_rvalid,
  input  logic            s_axi_rready,
  output axil_pkg::data_t s_axi_rdata,
  output axil_pkg::resp_t s_axi_rresp
);

  mem_port_if mem_bus0 ();

  axil_ctrl ctrl0 (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .awvalid       (s_axi_awvalid),
    .awready       (s_axi_awready),
    .awaddr        (s_axi_awaddr),
    .wvalid        (s_axi_wvalid),
    .wready        (s_axi_wready),
    .wdata         (s_axi_wdata),
    .wstrb         (s_axi_wstrb),
    .bvalid        (s_axi_bvalid),
    .bready        (s_axi_bready),
    .bresp         (s_axi_bresp),
    .arvalid       (s_axi_arvalid),
    .arready       (s_axi_arready),
    .araddr        (s_axi_araddr),
    .rvalid        (s_axi_rvalid),
    .rready        (s_axi_rready),
    .rdata         (s_axi_rdata),
    .rresp         (s_axi_rresp),
    .mem           (mem_bus0.ctrl)
  );

  axil_word_mem mem0 (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .port          (mem_bus0.mem)
  );

endmodule

//--- testbench/tb_axil_slave.sv
`timescale 1ns/1ns

`include "axil_params.svh"

module tb_axil_slave;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 2;
  localparam int RESET_READS  = 8;
  localparam int FULL_PAIRS   = 16;
  localparam int STROBE_PAIRS = 16;
  localparam int OOR_ROUNDS   = 8;
  localparam int RANDOM_OPS   = 200;
  localparam int NUM_TXN      = RESET_READS + 2 * FULL_PAIRS + 2 * STROBE_PAIRS +
                                3 * OOR_ROUNDS + RANDOM_OPS + `AXIL_MEM_DEPTH;
  localparam int WATCHDOG_NS  = NUM_TXN * 12 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

  logic            s_axi_aclk = 1'b0;
  logic            s_axi_aresetn;
  logic            s_axi_awvalid;
  logic            s_axi_awready;
  axil_pkg::addr_t s_axi_awaddr;
  logic            s_axi_wvalid;
  logic            s_axi_wready;
  axil_pkg::data_t s_axi_wdata;
  axil_pkg::strb_t s_axi_wstrb;
  logic            s_axi_bvalid;
  logic            s_axi_bready;
  axil_pkg::resp_t s_axi_bresp;
  logic            s_axi_arvalid;
  logic            s_axi_arready;
  axil_pkg::addr_t s_axi_araddr;
  logic            s_axi_rvalid;
  logic            s_axi_rready;
  axil_pkg::data_t s_axi_rdata;
  axil_pkg::resp_t s_axi_rresp;

  // Expected contents of the word memory.
  axil_pkg::data_t model [`AXIL_MEM_DEPTH];

  integer seed;
  int     errors;
  int     checks;

  always #(CLK_PERIOD / 2) s_axi_aclk = ~s_axi_aclk;

  axil_slave_top dut0 (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp)
  );

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("** Error [%s] expected %08h, actual %08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic ensure(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  function automatic logic [31:0] rand_below(input int unsigned limit);
    return $unsigned($random(seed)) % limit;
  endfunction

  function automatic axil_pkg::resp_t expected_resp(input axil_pkg::addr_t addr);
    if (addr < `AXIL_MEM_DEPTH) begin
      return `AXIL_RESP_OKAY;
    end
    return `AXIL_RESP_ERR;
  endfunction

  // Bit mask with all eight bits of every strobed lane set.
  function automatic axil_pkg::data_t strobe_mask(input axil_pkg::strb_t strb);
    axil_pkg::data_t mask;
    mask = '0;
    for (int i = 0; i < `AXIL_LANES; i++) begin
      if (strb[i]) begin
        mask[8*i +: 8] = 8'hff;
      end
    end
    return mask;
  endfunction

  task automatic model_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                             input axil_pkg::strb_t strb);
    axil_pkg::data_t mask;
    mask = strobe_mask(strb);
    if (addr < `AXIL_MEM_DEPTH) begin
      model[regfile_pkg::word_idx_t'(addr)] =
        (model[regfile_pkg::word_idx_t'(addr)] & ~mask) | (data & mask);
    end
  endtask

  // Called at a rising edge. AW and W are offered together and each valid
  // drops on the edge where its own handshake completes.
  // With follow_read set, the next read address is offered while the
  // response waits, and arready must stay low until the response is taken.
  task automatic write_word(input string name, input axil_pkg::addr_t addr,
                            input axil_pkg::data_t data, input axil_pkg::strb_t strb,
                            input logic follow_read, input axil_pkg::addr_t follow_addr);
    int              delay;
    logic            aw_done;
    logic            w_done;
    delay   = rand_below(4);
    aw_done = 1'b0;
    w_done  = 1'b0;
    s_axi_awvalid <= 1'b1;
    s_axi_awaddr  <= addr;
    s_axi_wvalid  <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= strb;
    while (!(aw_done && w_done)) begin
      @(posedge s_axi_aclk);
      if (s_axi_awvalid && s_axi_awready) begin
        aw_done = 1'b1;
        s_axi_awvalid <= 1'b0;
      end
      if (s_axi_wvalid && s_axi_wready) begin
        w_done = 1'b1;
        s_axi_wvalid <= 1'b0;
      end
    end
    while (!s_axi_bvalid) begin
      @(posedge s_axi_aclk);
    end
    if (follow_read) begin
      s_axi_arvalid <= 1'b1;
      s_axi_araddr  <= follow_addr;
    end
    compare_value({name, " bresp"}, 32'(expected_resp(addr)), 32'(s_axi_bresp));
    repeat (delay) begin
      @(posedge s_axi_aclk);
      ensure(s_axi_bvalid, "bvalid dropped while bready was held low");
      compare_value({name, " bresp hold"}, 32'(expected_resp(addr)), 32'(s_axi_bresp));
      ensure(!s_axi_awready && !s_axi_arready,
             "an address ready was raised while a write response was pending");
    end
    s_axi_bready <= 1'b1;
    @(posedge s_axi_aclk);
    ensure(s_axi_bvalid, "bvalid was low at the write response handshake");
    ensure(!s_axi_awready && !s_axi_arready,
           "an address ready was raised while a write response was pending");
    s_axi_bready <= 1'b0;
    model_write(addr, data, strb);
  endtask

  task automatic read_word(input string name, input axil_pkg::addr_t addr,
                           input logic follow_read, input axil_pkg::addr_t follow_addr);
    int              delay;
    axil_pkg::data_t data_exp;
    delay    = rand_below(4);
    data_exp = '0;
    if (addr < `AXIL_MEM_DEPTH) begin
      data_exp = model[regfile_pkg::word_idx_t'(addr)];
    end
    s_axi_arvalid <= 1'b1;
    s_axi_araddr  <= addr;
    @(posedge s_axi_aclk);
    while (!s_axi_arready) begin
      @(posedge s_axi_aclk);
    end
    s_axi_arvalid <= 1'b0;
    while (!s_axi_rvalid) begin
      @(posedge s_axi_aclk);
    end
    if (follow_read) begin
      s_axi_arvalid <= 1'b1;
      s_axi_araddr  <= follow_addr;
    end
    compare_value({name, " rresp"}, 32'(expected_resp(addr)), 32'(s_axi_rresp));
    compare_value({name, " rdata"}, data_exp, s_axi_rdata);
    repeat (delay) begin
      @(posedge s_axi_aclk);
      ensure(s_axi_rvalid, "rvalid dropped while rready was held low");
      compare_value({name, " rresp hold"}, 32'(expected_resp(addr)), 32'(s_axi_rresp));
      compare_value({name, " rdata hold"}, data_exp, s_axi_rdata);
      ensure(!s_axi_awready && !s_axi_arready,
             "an address ready was raised while a read response was pending");
    end
    s_axi_rready <= 1'b1;
    @(posedge s_axi_aclk);
    ensure(s_axi_rvalid, "rvalid was low at the read response handshake");
    ensure(!s_axi_awready && !s_axi_arready,
           "an address ready was raised while a read response was pending");
    s_axi_rready <= 1'b0;
  endtask

  initial begin : stimulus
    axil_pkg::addr_t addr;
    axil_pkg::addr_t oor_addr;
    axil_pkg::data_t data;
    axil_pkg::strb_t strb;
    seed   = 32'h0264cbfb;
    errors = 0;
    checks = 0;
    s_axi_aresetn <= 1'b0;
    s_axi_awvalid <= 1'b0;
    s_axi_awaddr  <= '0;
    s_axi_wvalid  <= 1'b0;
    s_axi_wdata   <= '0;
    s_axi_wstrb   <= '0;
    s_axi_bready  <= 1'b0;
    s_axi_arvalid <= 1'b0;
    s_axi_araddr  <= '0;
    s_axi_rready  <= 1'b0;
    for (int i = 0; i < `AXIL_MEM_DEPTH; i++) begin
      model[regfile_pkg::word_idx_t'(i)] = '0;
    end
    repeat (RESET_CYCLES) @(posedge s_axi_aclk);
    s_axi_aresetn <= 1'b1;
    @(posedge s_axi_aclk);

    ensure(!s_axi_bvalid && !s_axi_rvalid, "a response valid is high after reset");
    ensure(!s_axi_awready && !s_axi_wready && !s_axi_arready,
           "a channel ready is high after reset");
    compare_value("reset bresp", 32'(`AXIL_RESP_OKAY), 32'(s_axi_bresp));
    compare_value("reset rresp", 32'(`AXIL_RESP_OKAY), 32'(s_axi_rresp));
    compare_value("reset rdata", 32'h0, s_axi_rdata);
    repeat (RESET_READS) read_word("reset_read", rand_below(`AXIL_MEM_DEPTH), 1'b0, 32'h0);

    repeat (FULL_PAIRS) begin
      addr = rand_below(`AXIL_MEM_DEPTH);
      data = $random(seed);
      write_word("full_write", addr, data, 4'hf, 1'b1, addr);
      read_word("full_readback", addr, 1'b0, 32'h0);
    end

    repeat (STROBE_PAIRS) begin
      addr = rand_below(`AXIL_MEM_DEPTH);
      data = $random(seed);
      strb = axil_pkg::strb_t'(rand_below(16));
      write_word("strobe_write", addr, data, strb, 1'b1, addr);
      read_word("strobe_merge", addr, 1'b0, 32'h0);
    end

    // An ignored write to 128 + k must not alias onto word k.
    repeat (OOR_ROUNDS) begin
      addr     = rand_below(32);
      data     = $random(seed);
      oor_addr = `AXIL_MEM_DEPTH + rand_below(32);
      write_word("oor_write", `AXIL_MEM_DEPTH + addr, data, 4'hf, 1'b1, addr);
      read_word("oor_alias_read", addr, 1'b1, oor_addr);
      read_word("oor_read", oor_addr, 1'b0, 32'h0);
    end

    repeat (RANDOM_OPS) begin
      addr = rand_below(160);
      if (rand_below(2) == 0) begin
        data = $random(seed);
        strb = axil_pkg::strb_t'(rand_below(16));
        write_word("random_write", addr, data, strb, 1'b0, 32'h0);
      end else begin
        read_word("random_read", addr, 1'b0, 32'h0);
      end
    end

    for (int i = 0; i < `AXIL_MEM_DEPTH; i++) begin
      read_word("final_sweep", i, i < `AXIL_MEM_DEPTH - 1, i + 1);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish all transactions in %0d ns.", WATCHDOG_NS);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
hw/axil_pkg.sv
hw/regfile_pkg.sv
hw/mem_port_if.sv
hw/axil_ctrl.sv
hw/axil_word_mem.sv
hw/axil_slave_top.sv
testbench/tb_axil_slave.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_axil_slave -f tb.f || exit 1
out=$(./obj_dir/Vtb_axil_slave)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF -- '** PASS **' && exit 0 || exit 1
